//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_commit_trace
RTL_TOP   ?= commit_trace_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/core_cfg_pkg.sv
package core_cfg_pkg;

   // Issue and commit width
   localparam int n_lanes = 2;

   // Reorder buffer geometry
   localparam int n_banks = 2;
   localparam int rob_depth = 8;

   typedef logic [31:0] insn_t;

   // Word-aligned, low two bits dropped
   typedef logic [29:0] pc_t;

   typedef logic [4:0] lrf_addr_t;

   // Register data and exception vector
   typedef logic [31:0] data_t;

   typedef logic [$clog2(rob_depth)-1:0] rob_id_t;
   typedef logic [$clog2(n_banks)-1:0] bank_t;

   // Lanes allocating per cycle, 0 to n_lanes
   typedef logic [$clog2(n_lanes):0] push_size_t;

endpackage

//--- common/trace_pkg.sv
package trace_pkg;

   typedef logic [15:0] seq_t;

   // Record queue
   localparam int queue_depth = 4;
   typedef logic [$clog2(queue_depth)-1:0] qptr_t;

   // Drain machine states
   typedef enum logic [1:0]
   {
      drain_idle,
      drain_emit,
      drain_lost
   } drain_state_t;

endpackage

//--- shadow_rob/shadow_rob_store.sv
`timescale 1ns/100ps

module shadow_rob_store
   import core_cfg_pkg::*;
(
   input  logic       clk,
   input  insn_t      issue_ins [n_lanes],
   input  push_size_t rob_push_size,
   input  bank_t      rob_free_bank [n_lanes],
   input  rob_id_t    rob_free_id [n_lanes],
   input  bank_t      rob_head_l [n_lanes],
   input  rob_id_t    rob_que_rptr [n_banks],
   output insn_t      cmt_insn [n_lanes]
);

   insn_t rob_ins [n_banks][rob_depth];

   // Lane i allocates when i is below the push size
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < n_lanes; i++)
      begin
         if (i < int'(rob_push_size))
            rob_ins[rob_free_bank[i]][rob_free_id[i]] <= issue_ins[i];
      end
   end

   // Each lane reads its head bank at that bank's read pointer
   always_comb
   begin
      for (int i = 0; i < n_lanes; i++)
         cmt_insn[i] = rob_ins[rob_head_l[i]][rob_que_rptr[rob_head_l[i]]];
   end

   a_no_dual_write_same_entry : assert property (
      @(posedge clk)
      (int'(rob_push_size) == n_lanes) |->
         !(rob_free_bank[0] == rob_free_bank[1] && rob_free_id[0] == rob_free_id[1])
   );

   a_push_size_range : assert property (
      @(posedge clk) int'(rob_push_size) <= n_lanes
   );

endmodule

//--- src/commit_capture.sv
`timescale 1ns/100ps

module commit_capture
   import core_cfg_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [n_lanes-1:0] cmt_fire,
   input  pc_t                cmt_pc [n_lanes],
   input  lrf_addr_t          cmt_lrd [n_lanes],
   input  data_t              cmt_lrd_dat [n_lanes],
   input  logic [n_lanes-1:0] cmt_lrd_we,
   input  logic               cmt_exc,
   input  data_t              cmt_exc_vect,
   input  insn_t              cmt_insn [n_lanes],
   output logic [n_lanes-1:0] cap_valid,
   output pc_t                cap_pc [n_lanes],
   output insn_t              cap_insn [n_lanes],
   output logic [n_lanes-1:0] cap_wen,
   output lrf_addr_t          cap_wnum [n_lanes],
   output data_t              cap_wdata [n_lanes],
   output logic               cap_excp,
   output data_t              cap_excp_vect
);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cap_valid <= '0;
         cap_wen <= '0;
      end
      else
      begin
         cap_valid <= cmt_fire;
         // A write only counts on a lane that commits
         cap_wen <= cmt_lrd_we & cmt_fire;
      end
   end

   always_ff @(posedge clk)
   begin
      cap_pc <= cmt_pc;
      cap_insn <= cmt_insn;
      cap_wnum <= cmt_lrd;
      cap_wdata <= cmt_lrd_dat;
      cap_excp <= cmt_exc & cmt_fire[0];
      cap_excp_vect <= cmt_exc_vect;
   end

   a_exc_on_lane0 : assert property (
      @(posedge clk) disable iff (!rst_n) cmt_exc |-> cmt_fire[0]
   );

endmodule

//--- src/commit_seq_counter.sv
`timescale 1ns/100ps

module commit_seq_counter
   import core_cfg_pkg::*, trace_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [n_lanes-1:0] cap_valid,
   output seq_t               lane_seq [n_lanes]
);

   seq_t count;

   assign lane_seq[0] = count;
   assign lane_seq[1] = count + seq_t'(1);

   // Dropped records still consume numbers
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         count <= '0;
      else
         count <= count + seq_t'(cap_valid[0]) + seq_t'(cap_valid[1]);
   end

   // Commit is in order, lane 1 never retires alone
   a_lane1_needs_lane0 : assert property (
      @(posedge clk) disable iff (!rst_n) cap_valid[1] |-> cap_valid[0]
   );

endmodule

//--- src/commit_trace_top.sv
`timescale 1ns/100ps

module commit_trace_top
   import core_cfg_pkg::*, trace_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  insn_t              id_ins [n_lanes],
   input  logic               id_p_ce,
   input  logic               rn_p_ce,
   input  push_size_t         rob_push_size,
   input  bank_t              rob_free_bank [n_lanes],
   input  rob_id_t            rob_free_id [n_lanes],
   input  bank_t              rob_head_l [n_lanes],
   input  rob_id_t            rob_que_rptr [n_banks],
   input  logic [n_lanes-1:0] cmt_fire,
   input  pc_t                cmt_pc [n_lanes],
   input  lrf_addr_t          cmt_lrd [n_lanes],
   input  data_t              cmt_lrd_dat [n_lanes],
   input  logic [n_lanes-1:0] cmt_lrd_we,
   input  logic               cmt_exc,
   input  data_t              cmt_exc_vect,
   output logic               trace_valid,
   output seq_t               trace_seq,
   output pc_t                trace_pc,
   output insn_t              trace_insn,
   output logic               trace_wen,
   output lrf_addr_t          trace_wnum,
   output data_t              trace_wdata,
   output logic               trace_excp,
   output data_t              trace_excp_vect,
   output logic               trace_lost
);

   insn_t              issue_ins [n_lanes];
   insn_t              cmt_insn [n_lanes];
   logic [n_lanes-1:0] cap_valid;
   pc_t                cap_pc [n_lanes];
   insn_t              cap_insn [n_lanes];
   logic [n_lanes-1:0] cap_wen;
   lrf_addr_t          cap_wnum [n_lanes];
   data_t              cap_wdata [n_lanes];
   logic               cap_excp;
   data_t              cap_excp_vect;
   seq_t               lane_seq [n_lanes];
   logic               pop;
   logic               lost_clr;
   logic               empty;
   logic               lost;
   seq_t               head_seq;
   pc_t                head_pc;
   insn_t              head_insn;
   logic               head_wen;
   lrf_addr_t          head_wnum;
   data_t              head_wdata;
   logic               head_excp;
   data_t              head_excp_vect;

   insn_shadow_pipe insn_shadow_pipe_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .id_ins    (id_ins),
      .id_p_ce   (id_p_ce),
      .rn_p_ce   (rn_p_ce),
      .issue_ins (issue_ins)
   );

   shadow_rob_store shadow_rob_store_i (
      .clk           (clk),
      .issue_ins     (issue_ins),
      .rob_push_size (rob_push_size),
      .rob_free_bank (rob_free_bank),
      .rob_free_id   (rob_free_id),
      .rob_head_l    (rob_head_l),
      .rob_que_rptr  (rob_que_rptr),
      .cmt_insn      (cmt_insn)
   );

   commit_capture commit_capture_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmt_fire      (cmt_fire),
      .cmt_pc        (cmt_pc),
      .cmt_lrd       (cmt_lrd),
      .cmt_lrd_dat   (cmt_lrd_dat),
      .cmt_lrd_we    (cmt_lrd_we),
      .cmt_exc       (cmt_exc),
      .cmt_exc_vect  (cmt_exc_vect),
      .cmt_insn      (cmt_insn),
      .cap_valid     (cap_valid),
      .cap_pc        (cap_pc),
      .cap_insn      (cap_insn),
      .cap_wen       (cap_wen),
      .cap_wnum      (cap_wnum),
      .cap_wdata     (cap_wdata),
      .cap_excp      (cap_excp),
      .cap_excp_vect (cap_excp_vect)
   );

   commit_seq_counter commit_seq_counter_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cap_valid (cap_valid),
      .lane_seq  (lane_seq)
   );

   trace_record_queue trace_record_queue_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .cap_valid      (cap_valid),
      .cap_pc         (cap_pc),
      .cap_insn       (cap_insn),
      .cap_wen        (cap_wen),
      .cap_wnum       (cap_wnum),
      .cap_wdata      (cap_wdata),
      .cap_excp       (cap_excp),
      .cap_excp_vect  (cap_excp_vect),
      .lane_seq       (lane_seq),
      .pop            (pop),
      .lost_clr       (lost_clr),
      .empty          (empty),
      .lost           (lost),
      .head_seq       (head_seq),
      .head_pc        (head_pc),
      .head_insn      (head_insn),
      .head_wen       (head_wen),
      .head_wnum      (head_wnum),
      .head_wdata     (head_wdata),
      .head_excp      (head_excp),
      .head_excp_vect (head_excp_vect)
   );

   trace_drain_fsm trace_drain_fsm_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .empty       (empty),
      .lost        (lost),
      .pop         (pop),
      .lost_clr    (lost_clr),
      .trace_valid (trace_valid),
      .trace_lost  (trace_lost)
   );

   // Head record latched on the same edge that raises trace_valid
   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         trace_seq <= head_seq;
         trace_pc <= head_pc;
         trace_insn <= head_insn;
         trace_wen <= head_wen;
         trace_wnum <= head_wnum;
         trace_wdata <= head_wdata;
         trace_excp <= head_excp;
         trace_excp_vect <= head_excp_vect;
      end
   end

endmodule

//--- src/insn_shadow_pipe.sv
`timescale 1ns/100ps

module insn_shadow_pipe
   import core_cfg_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  insn_t id_ins [n_lanes],
   input  logic  id_p_ce,
   input  logic  rn_p_ce,
   output insn_t issue_ins [n_lanes]
);

   insn_t rn_ins [n_lanes];

   // Both stages hold whenever the core stalls them
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < n_lanes; i++)
         begin
            rn_ins[i] <= '0;
            issue_ins[i] <= '0;
         end
      end
      else
      begin
         if (id_p_ce)
            rn_ins <= id_ins;
         if (rn_p_ce)
            issue_ins <= rn_ins;
      end
   end

endmodule

//--- src/trace_drain_fsm.sv
`timescale 1ns/100ps

module trace_drain_fsm
   import trace_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic empty,
   input  logic lost,
   output logic pop,
   output logic lost_clr,
   output logic trace_valid,
   output logic trace_lost
);

   drain_state_t state_q;
   drain_state_t state_d;

   // Records always go before the lost marker
   always_comb
   begin
      pop = 1'b0;
      lost_clr = 1'b0;
      state_d = drain_idle;
      case (state_q)
         drain_idle, drain_emit:
         begin
            if (!empty)
            begin
               pop = 1'b1;
               state_d = drain_emit;
            end
            else if (lost)
            begin
               lost_clr = 1'b1;
               state_d = drain_lost;
            end
         end
         drain_lost:
         begin
            if (!empty)
            begin
               pop = 1'b1;
               state_d = drain_emit;
            end
         end
         default:
            state_d = drain_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= drain_idle;
      else
         state_q <= state_d;
   end

   assign trace_valid = (state_q == drain_emit);
   assign trace_lost = (state_q == drain_lost);

endmodule

//--- src/trace_record_queue.sv
`timescale 1ns/100ps

module trace_record_queue
   import core_cfg_pkg::*, trace_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [n_lanes-1:0] cap_valid,
   input  pc_t                cap_pc [n_lanes],
   input  insn_t              cap_insn [n_lanes],
   input  logic [n_lanes-1:0] cap_wen,
   input  lrf_addr_t          cap_wnum [n_lanes],
   input  data_t              cap_wdata [n_lanes],
   input  logic               cap_excp,
   input  data_t              cap_excp_vect,
   input  seq_t               lane_seq [n_lanes],
   input  logic               pop,
   input  logic               lost_clr,
   output logic               empty,
   output logic               lost,
   output seq_t               head_seq,
   output pc_t                head_pc,
   output insn_t              head_insn,
   output logic               head_wen,
   output lrf_addr_t          head_wnum,
   output data_t              head_wdata,
   output logic               head_excp,
   output data_t              head_excp_vect
);

   localparam int cnt_w = $clog2(queue_depth) + 1;
   localparam int rec_w = $bits(seq_t) + $bits(pc_t) + $bits(insn_t) + 1 +
                          $bits(lrf_addr_t) + 2 * $bits(data_t) + 1;

   typedef logic [rec_w-1:0] rec_t;

   rec_t             mem [queue_depth];
   rec_t             lane_rec [n_lanes];
   rec_t             slot_rec [n_lanes];
   rec_t             head_rec;
   qptr_t            wptr;
   qptr_t            rptr;
   logic [cnt_w-1:0] count;
   logic [cnt_w-1:0] free;
   logic [cnt_w-1:0] n_in;
   logic [cnt_w-1:0] n_acc;
   logic             drop;

   // Exception fields only exist on lane 0
   assign lane_rec[0] = {lane_seq[0], cap_pc[0], cap_insn[0], cap_wen[0], cap_wnum[0],
                         cap_wdata[0], cap_excp, cap_excp_vect};
   assign lane_rec[1] = {lane_seq[1], cap_pc[1], cap_insn[1], cap_wen[1], cap_wnum[1],
                         cap_wdata[1], 1'b0, {$bits(data_t){1'b0}}};

   // Lane 0 first, so lane 1 is what gets dropped
   assign slot_rec[0] = cap_valid[0] ? lane_rec[0] : lane_rec[1];
   assign slot_rec[1] = lane_rec[1];

   assign n_in = cnt_w'(cap_valid[0]) + cnt_w'(cap_valid[1]);
   assign free = cnt_w'(queue_depth) - count;
   assign drop = n_in > free;
   assign n_acc = drop ? free : n_in;

   // Empty queue passes the incoming record straight to the head
   assign empty = (count == '0) && (cap_valid == '0);
   assign head_rec = (count == '0) ? slot_rec[0] : mem[rptr];
   assign {head_seq, head_pc, head_insn, head_wen, head_wnum, head_wdata, head_excp,
           head_excp_vect} = head_rec;

   always_ff @(posedge clk)
   begin
      if (n_acc > cnt_w'(0))
         mem[wptr] <= slot_rec[0];
      if (n_acc > cnt_w'(1))
         mem[wptr + qptr_t'(1)] <= slot_rec[1];
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wptr <= '0;
         rptr <= '0;
         count <= '0;
         lost <= 1'b0;
      end
      else
      begin
         wptr <= wptr + qptr_t'(n_acc);
         rptr <= rptr + qptr_t'(pop);
         count <= count + n_acc - cnt_w'(pop);
         // Sticky, a new drop wins over the clear
         lost <= (lost & ~lost_clr) | drop;
      end
   end

   a_no_pop_empty : assert property (
      @(posedge clk) disable iff (!rst_n) pop |-> !empty
   );

   a_count_bound : assert property (
      @(posedge clk) disable iff (!rst_n) count <= cnt_w'(queue_depth)
   );

endmodule

//--- tb/tb_commit_trace.sv
`timescale 1ns/100ps

module tb_commit_trace
   import core_cfg_pkg::*, trace_pkg::*;
();

   localparam int max_rows = 24;

   logic               clk;
   logic               rst_n;
   insn_t              id_ins [n_lanes];
   logic               id_p_ce;
   logic               rn_p_ce;
   push_size_t         rob_push_size;
   bank_t              rob_free_bank [n_lanes];
   rob_id_t            rob_free_id [n_lanes];
   bank_t              rob_head_l [n_lanes];
   rob_id_t            rob_que_rptr [n_banks];
   logic [n_lanes-1:0] cmt_fire;
   pc_t                cmt_pc [n_lanes];
   lrf_addr_t          cmt_lrd [n_lanes];
   data_t              cmt_lrd_dat [n_lanes];
   logic [n_lanes-1:0] cmt_lrd_we;
   logic               cmt_exc;
   data_t              cmt_exc_vect;
   logic               trace_valid;
   seq_t               trace_seq;
   pc_t                trace_pc;
   insn_t              trace_insn;
   logic               trace_wen;
   lrf_addr_t          trace_wnum;
   data_t              trace_wdata;
   logic               trace_excp;
   data_t              trace_excp_vect;
   logic               trace_lost;

   // Operation table, one row per commit cycle
   int        n_rows = 0;
   int        t_test [max_rows];
   int        t_grp [max_rows];
   int        t_lanes [max_rows];
   int        t_exc [max_rows];
   int        t_stall [max_rows];
   bank_t     t_bank [max_rows][n_lanes];
   rob_id_t   t_id [max_rows][n_lanes];
   insn_t     t_insn [max_rows][n_lanes];
   pc_t       t_pc [max_rows][n_lanes];
   logic      t_we [max_rows][n_lanes];
   lrf_addr_t t_wnum [max_rows][n_lanes];
   data_t     t_wdata [max_rows][n_lanes];
   data_t     t_vect [max_rows];

   integer seed = 32'h509a_7683;
   int     seq_next = 0;
   int     cycles = 0;
   int     cycle_limit;

   commit_trace_top commit_trace_top_i (.*);

   trace_checker chk (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, trace port never finished", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic add_row(input int test, input int grp, input int lanes, input int b0,
                          input int i0, input int b1, input int i1, input int exc,
                          input int stall);
      t_test[n_rows] = test;
      t_grp[n_rows] = grp;
      t_lanes[n_rows] = lanes;
      t_exc[n_rows] = exc;
      t_stall[n_rows] = stall;
      t_bank[n_rows][0] = bank_t'(b0);
      t_id[n_rows][0] = rob_id_t'(i0);
      t_bank[n_rows][1] = bank_t'(b1);
      t_id[n_rows][1] = rob_id_t'(i1);
      t_vect[n_rows] = $random(seed);
      for (int l = 0; l < n_lanes; l++)
      begin
         t_insn[n_rows][l] = $random(seed);
         t_pc[n_rows][l] = pc_t'($random(seed));
         t_we[n_rows][l] = $random(seed);
         t_wnum[n_rows][l] = lrf_addr_t'($random(seed));
         t_wdata[n_rows][l] = $random(seed);
      end
      n_rows++;
   endtask

   task automatic build_table();
      add_row(2, 0, 1, 0, 0, 0, 0, 0, 0);
      add_row(2, 0, 1, 0, 1, 0, 0, 0, 0);
      add_row(2, 0, 1, 0, 2, 0, 0, 0, 0);
      add_row(3, 1, 2, 0, 3, 1, 3, 0, 0);
      add_row(3, 1, 2, 0, 4, 1, 4, 0, 0);
      add_row(4, 2, 1, 1, 5, 0, 0, 0, 1);
      add_row(4, 2, 2, 1, 2, 0, 7, 0, 1);
      add_row(4, 2, 1, 1, 0, 0, 0, 0, 0);
      add_row(5, 3, 1, 0, 1, 0, 0, 1, 0);
      // Burst fills every entry of both banks
      for (int k = 0; k < 8; k++)
         add_row(6, 4, 2, 0, k, 1, 7 - k, 0, 0);
      add_row(6, 5, 1, 0, 0, 0, 0, 0, 0);
   endtask

   // Decode, rename and allocate one row, with optional stalls in rename and issue
   task automatic allocate(input int r);
      @(posedge clk);
      id_ins <= t_insn[r];
      id_p_ce <= 1'b1;
      @(posedge clk);
      id_p_ce <= 1'b0;
      id_ins[0] <= $random(seed);
      id_ins[1] <= $random(seed);
      if (t_stall[r] != 0)
         @(posedge clk);
      rn_p_ce <= 1'b1;
      // Rename takes a new word while issue has to hold the old one
      if (t_stall[r] != 0)
         id_p_ce <= 1'b1;
      @(posedge clk);
      rn_p_ce <= 1'b0;
      id_p_ce <= 1'b0;
      if (t_stall[r] != 0)
         @(posedge clk);
      rob_push_size <= push_size_t'(t_lanes[r]);
      rob_free_bank <= t_bank[r];
      rob_free_id <= t_id[r];
      @(posedge clk);
      rob_push_size <= '0;
   endtask

   task automatic commit(input int r);
      for (int l = 0; l < t_lanes[r]; l++)
      begin
         chk.exp_pc[seq_next] = t_pc[r][l];
         chk.exp_insn[seq_next] = t_insn[r][l];
         chk.exp_wen[seq_next] = t_we[r][l];
         chk.exp_wnum[seq_next] = t_wnum[r][l];
         chk.exp_wdata[seq_next] = t_wdata[r][l];
         chk.exp_excp[seq_next] = (l == 0) && (t_exc[r] != 0);
         chk.exp_vect[seq_next] = t_vect[r];
         seq_next++;
      end
      chk.n_committed = seq_next;
      @(posedge clk);
      cmt_fire <= (t_lanes[r] == 2) ? 2'b11 : 2'b01;
      rob_head_l <= t_bank[r];
      rob_que_rptr[t_bank[r][0]] <= t_id[r][0];
      if (t_lanes[r] == 2)
         rob_que_rptr[t_bank[r][1]] <= t_id[r][1];
      cmt_pc <= t_pc[r];
      cmt_lrd <= t_wnum[r];
      cmt_lrd_dat <= t_wdata[r];
      cmt_lrd_we <= {t_we[r][1], t_we[r][0]};
      cmt_exc <= (t_exc[r] != 0);
      cmt_exc_vect <= t_vect[r];
   endtask

   initial
   begin
      int first;
      int last;
      int burst;
      rst_n = 1'b0;
      id_p_ce = 1'b0;
      rn_p_ce = 1'b0;
      rob_push_size = '0;
      cmt_fire = '0;
      cmt_lrd_we = '0;
      cmt_exc = 1'b0;
      cmt_exc_vect = '0;
      for (int l = 0; l < n_lanes; l++)
      begin
         id_ins[l] = '0;
         rob_free_bank[l] = '0;
         rob_free_id[l] = '0;
         rob_head_l[l] = bank_t'(l);
         rob_que_rptr[l] = '0;
         cmt_pc[l] = '0;
         cmt_lrd[l] = '0;
         cmt_lrd_dat[l] = '0;
      end
      build_table();
      cycle_limit = n_rows * 20 + 100;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // Idle trace port before any commit
      chk.cur_name = "reset idle";
      repeat (5) @(posedge clk);
      chk.end_test(1, 0);

      first = 0;
      while (first < n_rows)
      begin
         last = first;
         while (last + 1 < n_rows && t_grp[last + 1] == t_grp[first])
            last++;
         case (t_test[first])
            2: chk.cur_name = "single lane";
            3: chk.cur_name = "dual lane";
            4: chk.cur_name = "bank and order";
            5: chk.cur_name = "exception";
            default: chk.cur_name = "overflow";
         endcase
         burst = (last > first && t_test[first] == 6) ? last - first + 1 : 0;
         for (int r = first; r <= last; r++)
            allocate(r);
         for (int r = first; r <= last; r++)
            commit(r);
         @(posedge clk);
         cmt_fire <= '0;
         cmt_exc <= 1'b0;
         if (burst > 0)
            while (chk.lost_cnt == 0)
               @(posedge clk);
         else
            while (chk.rec_cnt + chk.skipped < seq_next)
               @(posedge clk);
         if (last + 1 >= n_rows || t_test[last + 1] != t_test[first])
            chk.end_test(t_test[first], (t_test[first] == 6) ? 8 : 0);
         first = last + 1;
      end

      chk.summary();
      if (chk.errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- tb/trace_checker.sv
`timescale 1ns/100ps

module trace_checker
   import core_cfg_pkg::*, trace_pkg::*;
(
   input logic      clk,
   input logic      rst_n,
   input logic      trace_valid,
   input seq_t      trace_seq,
   input pc_t       trace_pc,
   input insn_t     trace_insn,
   input logic      trace_wen,
   input lrf_addr_t trace_wnum,
   input data_t     trace_wdata,
   input logic      trace_excp,
   input data_t     trace_excp_vect,
   input logic      trace_lost
);

   // Expected records by sequence number, filled in by the core model
   pc_t       exp_pc [64];
   insn_t     exp_insn [64];
   logic      exp_wen [64];
   lrf_addr_t exp_wnum [64];
   data_t     exp_wdata [64];
   logic      exp_excp [64];
   data_t     exp_vect [64];
   int        n_committed = 0;

   int last_seq = -1;
   int rec_cnt = 0;
   int skipped = 0;
   int lost_cnt = 0;
   int lost_recs = 0;
   int errors = 0;
   int test_errs = 0;
   int test_recs = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;
   string cur_name = "reset";

   task automatic report_error(input string msg);
      $display("%s: %s", cur_name, msg);
      errors++;
      test_errs++;
   endtask

   task automatic compare_field(input string field, input int seq, input logic [31:0] exp,
                                input logic [31:0] act);
      if (exp !== act)
      begin
         $display("ERR %s seq %0d %s: expected %h actual %h", cur_name, seq, field, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   // Queue occupancy with one record drained per cycle
   function automatic int model_drops(input int cycles, input int lanes);
      int occ;
      int drops;
      int acc;
      occ = 0;
      drops = 0;
      for (int c = 0; c < cycles; c++)
      begin
         acc = (lanes < queue_depth - occ) ? lanes : queue_depth - occ;
         drops += lanes - acc;
         occ = occ + acc - 1;
      end
      return drops;
   endfunction

   always @(posedge clk)
   begin
      int s;
      if (rst_n)
      begin
         if (trace_valid && trace_lost)
            report_error("trace_valid and trace_lost high in the same cycle");
         if (trace_lost)
         begin
            lost_cnt++;
            lost_recs = test_recs;
         end
         if (trace_valid)
         begin
            s = int'(trace_seq);
            if (n_committed == 0)
               report_error("record appeared before any commit");
            else if (s >= n_committed || s <= last_seq)
               report_error($sformatf("sequence number %0d out of order", s));
            else
            begin
               skipped += s - last_seq - 1;
               compare_field("pc", s, 32'(exp_pc[s]), 32'(trace_pc));
               compare_field("insn", s, exp_insn[s], trace_insn);
               compare_field("wen", s, 32'(exp_wen[s]), 32'(trace_wen));
               compare_field("wnum", s, 32'(exp_wnum[s]), 32'(trace_wnum));
               compare_field("wdata", s, exp_wdata[s], trace_wdata);
               compare_field("excp", s, 32'(exp_excp[s]), 32'(trace_excp));
               if (exp_excp[s])
                  compare_field("excp_vect", s, exp_vect[s], trace_excp_vect);
               last_seq = s;
            end
            rec_cnt++;
            test_recs++;
         end
      end
   end

   task automatic end_test(input int idx, input int burst_cycles);
      int exp_drops;
      if (burst_cycles > 0)
      begin
         exp_drops = model_drops(burst_cycles, n_lanes);
         if (skipped != exp_drops)
            report_error($sformatf("%0d sequence numbers skipped where %0d records dropped",
                                   skipped, exp_drops));
         if (lost_cnt != 1)
            report_error($sformatf("%0d lost markers seen instead of one", lost_cnt));
         if (lost_recs != n_lanes * burst_cycles - exp_drops)
            report_error($sformatf("lost marker came after %0d of %0d surviving records",
                                   lost_recs, n_lanes * burst_cycles - exp_drops));
      end
      else if (lost_cnt != 0 || skipped != 0)
         report_error("lost marker or sequence gap without overflow");
      $display("test %0d %s: %s, %0d records", idx, cur_name,
               (test_errs == 0) ? "ok" : "FAILED", test_recs);
      if (test_errs == 0)
         pass_cnt++;
      else
         fail_cnt++;
      test_errs = 0;
      test_recs = 0;
   endtask

   task automatic summary();
      $display("Summary: %0d passed, %0d failed, %0d records, %0d skipped, %0d errors",
               pass_cnt, fail_cnt, rec_cnt, skipped, errors);
   endtask

endmodule

//--- verilog.f
common/core_cfg_pkg.sv
common/trace_pkg.sv
src/insn_shadow_pipe.sv
shadow_rob/shadow_rob_store.sv
src/commit_capture.sv
src/commit_seq_counter.sv
src/trace_record_queue.sv
src/trace_drain_fsm.sv
src/commit_trace_top.sv
tb/trace_checker.sv
tb/tb_commit_trace.sv
